// ==== files.f ====
+incdir+verif
hw/x86_flags_pkg.sv
hw/wb_uop_pkg.sv
hw/wb_flags_reg.sv
hw/wb_operand_select.sv
hw/wb_commit_ctrl.sv
hw/writeback.sv
verif/tb_writeback.sv

// ==== hw/wb_commit_ctrl.sv ====
// commit qualification, branch and cmovc resolution, repne/halt and stall for the writeback top
`timescale 1ns/1ps
`default_nettype none

module wb_commit_ctrl
   import x86_flags_pkg::*;
   import wb_uop_pkg::*;
(
   input  wire                      valid,
   input  wire [uop_ctrl_width-1:0] uop,
   input  wire                      ex_ld_gpr2,
   input  wire                      ex_dcache_write,
   input  wire                      repne,
   input  wire [31:0]               result_c,
   input  wire eflags_u             cur_flags,
   input  wire                      write_ready,
   output logic                     ld_gpr1,
   output logic                     ld_gpr2,
   output logic                     ld_gpr3,
   output logic                     ld_seg,
   output logic                     ld_mm,
   output logic                     ld_eip,
   output logic                     ld_cs,
   output logic                     dcache_write,
   output logic                     flags_load,
   output logic                     repne_term,
   output logic                     halt,
   output logic                     stall
);

   logic zf;
   logic cf;
   logic count_done;
   logic jne_block;
   logic jnbe_block;
   logic eip_request;
   logic gpr2_request;

   // conditions use the committed flags, not this op's result
   assign zf = cur_flags.bits.zf_flag;
   assign cf = cur_flags.bits.cf_flag;

   assign count_done = (result_c == 32'd0);

   // repne scan ends on a match or when ecx runs out
   assign repne_term = valid && repne && uop[uop_is_cmps_second] && (zf || count_done);

   // branch not taken keeps the sequential eip from fetch
   assign jne_block = uop[uop_is_jne] && zf;
   assign jnbe_block = uop[uop_is_jnbe] && (cf || zf);

   // a live repne loop reloads eip to repeat the cmps
   assign eip_request = uop[uop_ld_eip] && !jne_block && !jnbe_block && !repne_term;

   // cmovc moves only with carry set
   assign gpr2_request = ex_ld_gpr2 && (!uop[uop_is_cmovc] || cf);

   assign ld_gpr1 = valid && uop[uop_ld_gpr1];
   assign ld_gpr2 = valid && gpr2_request;
   assign ld_gpr3 = valid && uop[uop_ld_gpr3];
   assign ld_seg = valid && uop[uop_ld_seg];
   assign ld_mm = valid && uop[uop_ld_mm];
   assign ld_eip = valid && eip_request;
   assign ld_cs = valid && uop[uop_ld_cs];
   assign dcache_write = valid && ex_dcache_write;
   assign flags_load = valid && uop[uop_ld_flags];

   assign halt = valid && uop[uop_is_halt];

   // hold the stage until the cache write port frees up
   assign stall = dcache_write && !write_ready;

endmodule

`default_nettype wire

// ==== hw/wb_flags_reg.sv ====
// architectural flags register of the writeback stage, instantiated by the writeback top level
`timescale 1ns/1ps
`default_nettype none

module wb_flags_reg
   import x86_flags_pkg::*;
(
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire                    flags_load,
   input  wire                    stall,
   input  wire                    pop,
   input  wire [affect_width-1:0] affected,
   input  wire [31:0]             new_flags,
   input  wire [31:0]             pop_value,
   output eflags_u                cur_flags
);

   logic [31:0] merge_mask;
   logic [31:0] merged_flags;

   // spread the compact mask out to flag positions
   always_comb begin
      merge_mask = '0;
      merge_mask[flag_cf_bit] = affected[affect_cf];
      merge_mask[flag_pf_bit] = affected[affect_pf];
      merge_mask[flag_af_bit] = affected[affect_af];
      merge_mask[flag_zf_bit] = affected[affect_zf];
      merge_mask[flag_sf_bit] = affected[affect_sf];
      merge_mask[flag_df_bit] = affected[affect_df];
      merge_mask[flag_of_bit] = affected[affect_of];
   end

   // unaffected bits, reserved ones included, keep their old value
   assign merged_flags = (cur_flags.raw & ~merge_mask) | (new_flags & merge_mask);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cur_flags.raw <= flags_reset_value;
      end else if (flags_load && !stall) begin
         if (pop) begin
            // popf replaces the whole word
            cur_flags.raw <= pop_value;
         end else begin
            cur_flags.raw <= merged_flags;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/wb_operand_select.sv ====
// data1, eip and cs selection with the cmps save registers, instantiated by the writeback top
`timescale 1ns/1ps
`default_nettype none

module wb_operand_select
   import x86_flags_pkg::*;
   import wb_uop_pkg::*;
(
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      valid,
   input  wire                      stall,
   input  wire [uop_ctrl_width-1:0] uop,
   input  wire eflags_u             cur_flags,
   input  wire [31:0]               result_a,
   input  wire [31:0]               neip,
   input  wire [15:0]               ncs,
   output logic [31:0]              data1,
   output logic [31:0]              eip_value,
   output logic [31:0]              cs_value
);

   logic [31:0] temp_neip;
   logic [15:0] temp_ncs;
   logic        save_next;
   logic        use_temp;
   logic [15:0] cs_sel;

   // only a committed first half captures the return point
   assign save_next = valid && !stall && uop[uop_is_cmps_first];
   assign use_temp = uop[uop_is_cmps_second];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         temp_neip <= '0;
         temp_ncs <= '0;
      end else if (save_next) begin
         temp_neip <= neip;
         temp_ncs <= ncs;
      end
   end

   // pushf writes the flags word to the stack
   always_comb begin
      if (uop[uop_push_flags]) begin
         data1 = cur_flags.raw;
      end else begin
         data1 = result_a;
      end
   end

   // second half of cmps resumes at the saved point
   always_comb begin
      if (use_temp) begin
         eip_value = temp_neip;
         cs_sel = temp_ncs;
      end else begin
         eip_value = neip;
         cs_sel = ncs;
      end
   end

   assign cs_value = {16'd0, cs_sel};

endmodule

`default_nettype wire

// ==== hw/wb_uop_pkg.sv ====
// writeback micro-op control word fields and datasize codes, imported by the stage and testbench
`default_nettype none

package wb_uop_pkg;

   localparam int uop_ctrl_width = 16;

   // architectural load requests
   localparam int uop_ld_gpr1 = 0;
   localparam int uop_ld_gpr3 = 1;
   localparam int uop_ld_seg = 2;
   localparam int uop_ld_mm = 3;
   localparam int uop_ld_eip = 4;
   localparam int uop_ld_cs = 5;
   localparam int uop_ld_flags = 6;

   // flags stack traffic
   localparam int uop_pop_flags = 7;
   localparam int uop_push_flags = 8;

   // conditional commits
   localparam int uop_is_jne = 9;
   localparam int uop_is_jnbe = 10;
   localparam int uop_is_cmovc = 11;

   // the two halves of cmps
   localparam int uop_is_cmps_first = 12;
   localparam int uop_is_cmps_second = 13;

   localparam int uop_is_halt = 14;
   // cache data comes from the mm result
   localparam int uop_mm_mem = 15;

   // operand size, passed straight to the register file
   localparam int datasize_width = 2;
   localparam logic [1:0] size_8 = 2'd0;
   localparam logic [1:0] size_16 = 2'd1;
   localparam logic [1:0] size_32 = 2'd2;

endpackage

`default_nettype wire

// ==== hw/writeback.sv ====
// writeback stage top level, placed after execute and driving register, cache and eip/cs ports
`timescale 1ns/1ps
`default_nettype none

module writeback
   import x86_flags_pkg::*;
   import wb_uop_pkg::*;
(
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      valid,
   input  wire [uop_ctrl_width-1:0] uop,
   input  wire [affect_width-1:0]   affected,
   input  wire [datasize_width-1:0] datasize,
   input  wire                      ex_ld_gpr2,
   input  wire                      ex_dcache_write,
   input  wire                      repne,
   input  wire [31:0]               result_a,
   input  wire [31:0]               result_b,
   input  wire [31:0]               result_c,
   input  wire [31:0]               new_flags,
   input  wire [63:0]               result_mm,
   input  wire [2:0]                dr1,
   input  wire [2:0]                dr2,
   input  wire [2:0]                dr3,
   input  wire [31:0]               neip,
   input  wire [15:0]               ncs,
   input  wire [31:0]               address,
   input  wire                      write_ready,
   output logic [2:0]               final_dr1,
   output logic [2:0]               final_dr2,
   output logic [2:0]               final_dr3,
   output logic [31:0]              final_data1,
   output logic [31:0]              final_data2,
   output logic [31:0]              final_data3,
   output logic                     final_ld_gpr1,
   output logic                     final_ld_gpr2,
   output logic                     final_ld_gpr3,
   output logic [datasize_width-1:0] final_datasize,
   output logic                     final_ld_seg,
   output logic [63:0]              final_mm_data,
   output logic                     final_ld_mm,
   output logic [31:0]              final_eip,
   output logic                     final_ld_eip,
   output logic [31:0]              final_cs,
   output logic                     final_ld_cs,
   output logic [63:0]              dcache_data,
   output logic [31:0]              dcache_address,
   output logic                     dcache_write,
   output logic                     halt,
   output logic                     repne_term,
   output logic                     stall,
   output logic                     cf_fwd,
   output logic                     af_fwd
);

   eflags_u     cur_flags;
   logic        flags_load;
   logic [31:0] data1;

   wb_flags_reg u_flags_reg (
      .clk        (clk),
      .rst_n      (rst_n),
      .flags_load (flags_load),
      .stall      (stall),
      .pop        (uop[uop_pop_flags]),
      .affected   (affected),
      .new_flags  (new_flags),
      .pop_value  (result_a),
      .cur_flags  (cur_flags)
   );

   wb_operand_select u_operand_select (
      .clk       (clk),
      .rst_n     (rst_n),
      .valid     (valid),
      .stall     (stall),
      .uop       (uop),
      .cur_flags (cur_flags),
      .result_a  (result_a),
      .neip      (neip),
      .ncs       (ncs),
      .data1     (data1),
      .eip_value (final_eip),
      .cs_value  (final_cs)
   );

   wb_commit_ctrl u_commit_ctrl (
      .valid           (valid),
      .uop             (uop),
      .ex_ld_gpr2      (ex_ld_gpr2),
      .ex_dcache_write (ex_dcache_write),
      .repne           (repne),
      .result_c        (result_c),
      .cur_flags       (cur_flags),
      .write_ready     (write_ready),
      .ld_gpr1         (final_ld_gpr1),
      .ld_gpr2         (final_ld_gpr2),
      .ld_gpr3         (final_ld_gpr3),
      .ld_seg          (final_ld_seg),
      .ld_mm           (final_ld_mm),
      .ld_eip          (final_ld_eip),
      .ld_cs           (final_ld_cs),
      .dcache_write    (dcache_write),
      .flags_load      (flags_load),
      .repne_term      (repne_term),
      .halt            (halt),
      .stall           (stall)
   );

   // register file side
   assign final_dr1 = dr1;
   assign final_dr2 = dr2;
   assign final_dr3 = dr3;
   assign final_data1 = data1;
   assign final_data2 = result_b;
   assign final_data3 = result_c;
   assign final_datasize = datasize;
   assign final_mm_data = result_mm;

   // the cache port is 64 bits wide for mm stores
   assign dcache_data = uop[uop_mm_mem] ? result_mm : {32'd0, data1};
   assign dcache_address = address;

   // forwarded from the committed flags
   assign cf_fwd = cur_flags.bits.cf_flag;
   assign af_fwd = cur_flags.bits.af_flag;

endmodule

`default_nettype wire

// ==== hw/x86_flags_pkg.sv ====
// x86 flags word layout and reset value, imported by the writeback stage and its testbench
`default_nettype none

package x86_flags_pkg;

   // bit positions inside the 32-bit flags word
   localparam int flag_cf_bit = 0;
   localparam int flag_pf_bit = 2;
   localparam int flag_af_bit = 4;
   localparam int flag_zf_bit = 6;
   localparam int flag_sf_bit = 7;
   localparam int flag_df_bit = 10;
   localparam int flag_of_bit = 11;

   // bit 1 always reads as one
   localparam logic [31:0] flags_reset_value = 32'h0000_0002;

   // affected-flag mask from execute, one bit per named flag
   localparam int affect_width = 7;
   localparam int affect_cf = 0;
   localparam int affect_pf = 1;
   localparam int affect_af = 2;
   localparam int affect_zf = 3;
   localparam int affect_sf = 4;
   localparam int affect_df = 5;
   localparam int affect_of = 6;

   typedef struct packed {
      logic [19:0] rsvd_31_12;
      logic        of_flag;
      logic        df_flag;
      logic [1:0]  rsvd_9_8;
      logic        sf_flag;
      logic        zf_flag;
      logic        rsvd_5;
      logic        af_flag;
      logic        rsvd_3;
      logic        pf_flag;
      logic        rsvd_1;
      logic        cf_flag;
   } eflags_bits_t;

   // raw view for push/pop, named view for condition checks
   typedef union packed {
      logic [31:0]  raw;
      eflags_bits_t bits;
   } eflags_u;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the writeback testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_writeback -o tb_writeback
status=$?
if [ "$status" -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit "$status"
fi

./obj_dir/tb_writeback
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit "$status"
fi

exit 0

// ==== verif/tb_writeback_tests.svh ====
// directed writeback test tasks, included into the body of the writeback testbench module

// returns the flags word position of one affected-mask bit
function automatic int flag_position(input int idx);
   case (idx)
      affect_cf: return flag_cf_bit;
      affect_pf: return flag_pf_bit;
      affect_af: return flag_af_bit;
      affect_zf: return flag_zf_bit;
      affect_sf: return flag_sf_bit;
      affect_df: return flag_df_bit;
      default: return flag_of_bit;
   endcase
endfunction

function automatic logic [31:0] merge_expected(input logic [31:0] old_word,
                                               input logic [31:0] upd,
                                               input logic [6:0] mask);
   logic [31:0] result;
   int pos;
   result = old_word;
   for (int i = 0; i < affect_width; i++) begin
      pos = flag_position(i);
      if (mask[i]) begin
         result[pos] = upd[pos];
      end
   end
   return result;
endfunction

task automatic clear_inputs();
   valid = 1'b0;
   uop = '0;
   affected = '0;
   datasize = size_32;
   ex_ld_gpr2 = 1'b0;
   ex_dcache_write = 1'b0;
   repne = 1'b0;
   result_a = '0;
   result_b = '0;
   result_c = '0;
   new_flags = '0;
   result_mm = '0;
   dr1 = '0;
   dr2 = '0;
   dr3 = '0;
   neip = '0;
   ncs = '0;
   address = '0;
   write_ready = 1'b1;
endtask

task automatic set_load_requests(input logic [5:0] req);
   uop[uop_ld_gpr1] = req[0];
   uop[uop_ld_gpr3] = req[1];
   uop[uop_ld_seg] = req[2];
   uop[uop_ld_mm] = req[3];
   uop[uop_ld_eip] = req[4];
   uop[uop_ld_cs] = req[5];
endtask

// popf of a known word, committed at the next rising edge
task automatic load_flags(input logic [31:0] value);
   @(negedge clk);
   clear_inputs();
   valid = 1'b1;
   uop[uop_ld_flags] = 1'b1;
   uop[uop_pop_flags] = 1'b1;
   result_a = value;
   flags_model = value;
endtask

// pushf shows the whole flags word on data1
task automatic read_back_flags();
   @(negedge clk);
   clear_inputs();
   valid = 1'b1;
   uop[uop_push_flags] = 1'b1;
   #1;
   check_value("final_data1", 64'(final_data1), 64'(flags_model));
   check_value("cf_fwd", 64'(cf_fwd), 64'(flags_model[flag_cf_bit]));
   check_value("af_fwd", 64'(af_fwd), 64'(flags_model[flag_af_bit]));
endtask

task automatic test_qualification();
   logic [5:0] req;
   logic       gpr2_req;
   logic       wr_req;
   logic       mm_sel;
   @(negedge clk);
   clear_inputs();
   set_load_requests(6'h3f);
   uop[uop_is_halt] = 1'b1;
   uop[uop_is_cmps_second] = 1'b1;
   repne = 1'b1;
   ex_ld_gpr2 = 1'b1;
   ex_dcache_write = 1'b1;
   write_ready = 1'b0;
   #1;
   // nothing commits without valid
   check_value("final_ld_gpr1", 64'(final_ld_gpr1), 64'(0));
   check_value("final_ld_gpr2", 64'(final_ld_gpr2), 64'(0));
   check_value("final_ld_gpr3", 64'(final_ld_gpr3), 64'(0));
   check_value("final_ld_seg", 64'(final_ld_seg), 64'(0));
   check_value("final_ld_mm", 64'(final_ld_mm), 64'(0));
   check_value("final_ld_eip", 64'(final_ld_eip), 64'(0));
   check_value("final_ld_cs", 64'(final_ld_cs), 64'(0));
   check_value("dcache_write", 64'(dcache_write), 64'(0));
   check_value("halt", 64'(halt), 64'(0));
   check_value("stall", 64'(stall), 64'(0));
   check_value("repne_term", 64'(repne_term), 64'(0));
   for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      clear_inputs();
      valid = 1'b1;
      req = 6'($urandom);
      gpr2_req = 1'($urandom);
      wr_req = 1'($urandom);
      mm_sel = 1'($urandom);
      set_load_requests(req);
      uop[uop_mm_mem] = mm_sel;
      ex_ld_gpr2 = gpr2_req;
      ex_dcache_write = wr_req;
      result_a = $urandom;
      result_b = $urandom;
      result_c = $urandom;
      result_mm = {$urandom, $urandom};
      dr1 = 3'($urandom);
      dr2 = 3'($urandom);
      dr3 = 3'($urandom);
      datasize = 2'($urandom % 3);
      address = $urandom;
      #1;
      check_value("final_ld_gpr1", 64'(final_ld_gpr1), 64'(req[0]));
      check_value("final_ld_gpr3", 64'(final_ld_gpr3), 64'(req[1]));
      check_value("final_ld_seg", 64'(final_ld_seg), 64'(req[2]));
      check_value("final_ld_mm", 64'(final_ld_mm), 64'(req[3]));
      check_value("final_ld_eip", 64'(final_ld_eip), 64'(req[4]));
      check_value("final_ld_cs", 64'(final_ld_cs), 64'(req[5]));
      check_value("final_ld_gpr2", 64'(final_ld_gpr2), 64'(gpr2_req));
      check_value("dcache_write", 64'(dcache_write), 64'(wr_req));
      check_value("stall", 64'(stall), 64'(0));
      check_value("final_data1", 64'(final_data1), 64'(result_a));
      check_value("final_data2", 64'(final_data2), 64'(result_b));
      check_value("final_data3", 64'(final_data3), 64'(result_c));
      check_value("final_dr1", 64'(final_dr1), 64'(dr1));
      check_value("final_dr2", 64'(final_dr2), 64'(dr2));
      check_value("final_dr3", 64'(final_dr3), 64'(dr3));
      check_value("final_datasize", 64'(final_datasize), 64'(datasize));
      check_value("final_mm_data", final_mm_data, result_mm);
      check_value("dcache_address", 64'(dcache_address), 64'(address));
      check_value("dcache_data", dcache_data, mm_sel ? result_mm : {32'd0, result_a});
   end
endtask

task automatic test_flags();
   logic [31:0] upd;
   logic [6:0]  mask;
   // reset value has only bit 1 set
   read_back_flags();
   check_value("final_data1", 64'(final_data1), 64'h2);
   for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      clear_inputs();
      valid = 1'b1;
      uop[uop_ld_flags] = 1'b1;
      upd = $urandom;
      mask = 7'($urandom);
      new_flags = upd;
      affected = mask;
      flags_model = merge_expected(flags_model, upd, mask);
      read_back_flags();
   end
   // pop ignores the mask and new_flags
   upd = $urandom;
   load_flags(upd);
   affected = '1;
   new_flags = ~upd;
   read_back_flags();
endtask

task automatic test_conditionals();
   logic cf;
   logic zf;
   for (int combo = 0; combo < 4; combo++) begin
      cf = combo[0];
      zf = combo[1];
      load_flags(32'h2 | (32'(cf) << flag_cf_bit) | (32'(zf) << flag_zf_bit));
      @(negedge clk);
      clear_inputs();
      valid = 1'b1;
      uop[uop_ld_eip] = 1'b1;
      uop[uop_is_jne] = 1'b1;
      #1;
      check_value("final_ld_eip", 64'(final_ld_eip), 64'(!zf));
      @(negedge clk);
      clear_inputs();
      valid = 1'b1;
      uop[uop_ld_eip] = 1'b1;
      uop[uop_is_jnbe] = 1'b1;
      #1;
      check_value("final_ld_eip", 64'(final_ld_eip), 64'(!cf && !zf));
      @(negedge clk);
      clear_inputs();
      valid = 1'b1;
      uop[uop_is_cmovc] = 1'b1;
      ex_ld_gpr2 = 1'b1;
      #1;
      check_value("final_ld_gpr2", 64'(final_ld_gpr2), 64'(cf));
   end
endtask

task automatic test_cmps_repne();
   logic [31:0] saved_eip;
   logic [15:0] saved_cs;
   logic [31:0] count;
   logic        zf;
   logic        term;
   saved_eip = $urandom;
   saved_cs = 16'($urandom);
   @(negedge clk);
   clear_inputs();
   valid = 1'b1;
   uop[uop_is_cmps_first] = 1'b1;
   neip = saved_eip;
   ncs = saved_cs;
   #1;
   check_value("final_eip", 64'(final_eip), 64'(saved_eip));
   check_value("final_cs", 64'(final_cs), {48'd0, saved_cs});
   @(negedge clk);
   clear_inputs();
   valid = 1'b1;
   uop[uop_is_cmps_second] = 1'b1;
   uop[uop_ld_eip] = 1'b1;
   neip = ~saved_eip;
   ncs = ~saved_cs;
   #1;
   check_value("final_eip", 64'(final_eip), 64'(saved_eip));
   check_value("final_cs", 64'(final_cs), {48'd0, saved_cs});
   check_value("final_ld_eip", 64'(final_ld_eip), 64'(1));
   check_value("repne_term", 64'(repne_term), 64'(0));
   // zf set, count exhausted, then neither
   for (int c = 0; c < 3; c++) begin
      zf = (c == 0);
      count = (c == 1) ? 32'd0 : ($urandom | 32'd1);
      load_flags(32'h2 | (32'(zf) << flag_zf_bit));
      @(negedge clk);
      clear_inputs();
      valid = 1'b1;
      repne = 1'b1;
      uop[uop_is_cmps_second] = 1'b1;
      uop[uop_ld_eip] = 1'b1;
      result_c = count;
      #1;
      term = zf || (count == 32'd0);
      check_value("repne_term", 64'(repne_term), 64'(term));
      check_value("final_ld_eip", 64'(final_ld_eip), 64'(!term));
   end
endtask

task automatic drive_stalled_update(input logic [31:0] upd, input logic ready);
   @(negedge clk);
   clear_inputs();
   valid = 1'b1;
   uop[uop_ld_flags] = 1'b1;
   affected = '1;
   new_flags = upd;
   ex_dcache_write = 1'b1;
   write_ready = ready;
   #1;
endtask

task automatic test_stall_halt();
   logic [31:0] upd;
   load_flags(32'h2);
   upd = ~flags_model;
   for (int i = 0; i < 3; i++) begin
      drive_stalled_update(upd, 1'b0);
      check_value("stall", 64'(stall), 64'(1));
      check_value("dcache_write", 64'(dcache_write), 64'(1));
      // held flags, cf and af would flip on a commit
      check_value("cf_fwd", 64'(cf_fwd), 64'(flags_model[flag_cf_bit]));
      check_value("af_fwd", 64'(af_fwd), 64'(flags_model[flag_af_bit]));
   end
   drive_stalled_update(upd, 1'b1);
   check_value("stall", 64'(stall), 64'(0));
   flags_model = merge_expected(flags_model, upd, 7'h7f);
   read_back_flags();
   @(negedge clk);
   clear_inputs();
   valid = 1'b1;
   uop[uop_is_halt] = 1'b1;
   #1;
   check_value("halt", 64'(halt), 64'(1));
   @(negedge clk);
   clear_inputs();
   uop[uop_is_halt] = 1'b1;
   #1;
   check_value("halt", 64'(halt), 64'(0));
endtask

// ==== verif/tb_writeback.sv ====
// directed testbench for the writeback stage, compiled with the RTL through the file list
`timescale 1ns/1ps
`default_nettype none

module tb_writeback
   import x86_flags_pkg::*;
   import wb_uop_pkg::*;
();

   // about 60 test cycles, with a wide margin
   localparam int timeout_cycles = 400;

   logic                      clk;
   logic                      rst_n;
   logic                      valid;
   logic [uop_ctrl_width-1:0] uop;
   logic [affect_width-1:0]   affected;
   logic [datasize_width-1:0] datasize;
   logic                      ex_ld_gpr2;
   logic                      ex_dcache_write;
   logic                      repne;
   logic [31:0]               result_a, result_b, result_c;
   logic [31:0]               new_flags;
   logic [63:0]               result_mm;
   logic [2:0]                dr1, dr2, dr3;
   logic [31:0]               neip;
   logic [15:0]               ncs;
   logic [31:0]               address;
   logic                      write_ready;

   logic [2:0]                final_dr1, final_dr2, final_dr3;
   logic [31:0]               final_data1, final_data2, final_data3;
   logic                      final_ld_gpr1, final_ld_gpr2, final_ld_gpr3;
   logic [datasize_width-1:0] final_datasize;
   logic                      final_ld_seg;
   logic [63:0]               final_mm_data;
   logic                      final_ld_mm;
   logic [31:0]               final_eip;
   logic                      final_ld_eip;
   logic [31:0]               final_cs;
   logic                      final_ld_cs;
   logic [63:0]               dcache_data;
   logic [31:0]               dcache_address;
   logic                      dcache_write;
   logic                      halt;
   logic                      repne_term;
   logic                      stall;
   logic                      cf_fwd;
   logic                      af_fwd;

   // expected architectural flags word
   logic [31:0] flags_model;
   int cycle_count = 0;

   writeback u_writeback (.*);

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
         $display("timeout: tests still running after %0d cycles", cycle_count);
         $display("Verification failed");
         $fatal(1, "run stopped by the cycle limit");
      end
   end

   task automatic check_value(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         $display("** Error: %s = %h, expected %h", name, actual, expected);
         $display("Verification failed");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   `include "tb_writeback_tests.svh"

   initial begin
      void'($urandom(32'hada1));
      clk = 1'b0;
      rst_n = 1'b0;
      clear_inputs();
      flags_model = 32'h0000_0002;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      test_flags();
      test_qualification();
      test_conditionals();
      test_cmps_repne();
      test_stall_halt();

      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire
